// File: axil_div_regs.sv
`timescale 1ns/1ns
`default_nettype none

module axil_div_regs (
	input  wire logic                          clk_i,
	input  wire logic                          arst_n_i,

	input  wire logic [axil_pkg::ADDR_W-1:0]   s_awaddr_i,
	input  wire logic                          s_awvalid_i,
	output logic                               s_awready_o,

	input  wire logic [axil_pkg::DATA_W-1:0]   s_wdata_i,
	input  wire logic                          s_wvalid_i,
	output logic                               s_wready_o,

	output logic      [axil_pkg::RESP_W-1:0]   s_bresp_o,
	output logic                               s_bvalid_o,
	input  wire logic                          s_bready_i,

	input  wire logic [axil_pkg::ADDR_W-1:0]   s_araddr_i,
	input  wire logic                          s_arvalid_i,
	output logic                               s_arready_o,

	output logic      [axil_pkg::DATA_W-1:0]   s_rdata_o,
	output logic      [axil_pkg::RESP_W-1:0]   s_rresp_o,
	output logic                               s_rvalid_o,
	input  wire logic                          s_rready_i,

	div_if.ctrl                                div_p
);

	logic [axil_pkg::DATA_W-1:0] opa_q;
	logic [axil_pkg::DATA_W-1:0] opb_q;
	mdu_pkg::div_op_e            op_q;
	logic                        start_q;
	logic                        done_q;      // sticky until CTRL write.
	logic [axil_pkg::DATA_W-1:0] result_q;

	logic                        bvalid_q;
	logic [axil_pkg::RESP_W-1:0] bresp_q;
	logic                        rvalid_q;
	logic [axil_pkg::RESP_W-1:0] rresp_q;
	logic [axil_pkg::DATA_W-1:0] rdata_q;

	logic                        wr_acc;
	logic                        rd_acc;
	logic                        busy_eff;
	logic                        wr_opa;
	logic                        wr_opb;
	logic                        wr_ctrl;
	logic [axil_pkg::RESP_W-1:0] wr_resp;
	logic [axil_pkg::DATA_W-1:0] rd_data;
	logic [axil_pkg::RESP_W-1:0] rd_resp;

	// one transaction per channel.
	assign wr_acc   = s_awvalid_i && s_wvalid_i && !bvalid_q;
	assign rd_acc   = s_arvalid_i && !rvalid_q;
	assign busy_eff = div_p.busy | start_q;  // covers the start cycle.

	// ========================================
	// write decode
	// ========================================
	always_comb begin
		wr_opa  = 1'b0;
		wr_opb  = 1'b0;
		wr_ctrl = 1'b0;
		wr_resp = axil_pkg::RESP_DECERR;
		case (s_awaddr_i)
			axil_pkg::REG_OPA: begin
				wr_opa  = 1'b1;
				wr_resp = axil_pkg::RESP_OKAY;
			end
			axil_pkg::REG_OPB: begin
				wr_opb  = 1'b1;
				wr_resp = axil_pkg::RESP_OKAY;
			end
			axil_pkg::REG_CTRL: begin
				if (busy_eff) begin
					wr_resp = axil_pkg::RESP_SLVERR;  // refused, no effect.
				end else begin
					wr_ctrl = 1'b1;
					wr_resp = axil_pkg::RESP_OKAY;
				end
			end
			default: begin
			end
		endcase
	end

	// read mux.
	always_comb begin
		rd_data = '0;
		rd_resp = axil_pkg::RESP_OKAY;
		case (s_araddr_i)
			axil_pkg::REG_OPA:    rd_data = opa_q;
			axil_pkg::REG_OPB:    rd_data = opb_q;
			axil_pkg::REG_CTRL:   rd_data = {{(axil_pkg::DATA_W-2){1'b0}}, op_q};
			axil_pkg::REG_STATUS: rd_data = {{(axil_pkg::DATA_W-2){1'b0}}, done_q, busy_eff};
			axil_pkg::REG_RESULT: rd_data = result_q;
			default:              rd_resp = axil_pkg::RESP_DECERR;
		endcase
	end

	// ========================================
	// registers
	// ========================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			opa_q    <= '0;
			opb_q    <= '0;
			op_q     <= mdu_pkg::OP_DIVU;
			start_q  <= 1'b0;
			done_q   <= 1'b0;
			result_q <= '0;
		end else begin
			start_q <= wr_acc && wr_ctrl;
			if (wr_acc && wr_opa) begin
				opa_q <= s_wdata_i;
			end
			if (wr_acc && wr_opb) begin
				opb_q <= s_wdata_i;
			end
			if (wr_acc && wr_ctrl) begin
				op_q   <= mdu_pkg::div_op_e'(s_wdata_i[1:0]);
				done_q <= 1'b0;
			end else if (div_p.done) begin
				done_q <= 1'b1;
			end
			if (div_p.done) begin
				result_q <= div_p.result;
			end
		end
	end

	// responses held until accepted.
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bvalid_q <= 1'b0;
			bresp_q  <= axil_pkg::RESP_OKAY;
			rvalid_q <= 1'b0;
			rresp_q  <= axil_pkg::RESP_OKAY;
			rdata_q  <= '0;
		end else begin
			if (wr_acc) begin
				bvalid_q <= 1'b1;
				bresp_q  <= wr_resp;
			end else if (s_bready_i) begin
				bvalid_q <= 1'b0;
			end
			if (rd_acc) begin
				rvalid_q <= 1'b1;
				rresp_q  <= rd_resp;
				rdata_q  <= rd_data;
			end else if (s_rready_i) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	assign s_awready_o = wr_acc;
	assign s_wready_o  = wr_acc;
	assign s_bvalid_o  = bvalid_q;
	assign s_bresp_o   = bresp_q;
	assign s_arready_o = rd_acc;
	assign s_rvalid_o  = rvalid_q;
	assign s_rresp_o   = rresp_q;
	assign s_rdata_o   = rdata_q;

	assign div_p.start    = start_q;
	assign div_p.op       = op_q;
	assign div_p.dividend = opa_q;
	assign div_p.divisor  = opb_q;

endmodule

`default_nettype wire

// File: axil_pkg.sv
`default_nettype none

package axil_pkg;

	// ========================================
	// bus widths
	// ========================================
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;
	localparam int RESP_W = 2;

	// register map.
	localparam logic [ADDR_W-1:0] REG_OPA    = 8'h00;  // dividend.
	localparam logic [ADDR_W-1:0] REG_OPB    = 8'h04;  // divisor.
	localparam logic [ADDR_W-1:0] REG_CTRL   = 8'h08;  // op, write starts.
	localparam logic [ADDR_W-1:0] REG_STATUS = 8'h0C;  // busy, sticky done.
	localparam logic [ADDR_W-1:0] REG_RESULT = 8'h10;

	// response codes.
	localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
	localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;
	localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

// File: div_accel.f
mdu_pkg.sv
axil_pkg.sv
div_if.sv
int_divider.sv
axil_div_regs.sv
div_accel_top.sv
tb_div_accel_sva.sv
tb_div_accel.sv

// File: div_accel_top.sv
`timescale 1ns/1ns
`default_nettype none

module div_accel_top (
	input  wire logic                          clk_i,
	input  wire logic                          arst_n_i,

	input  wire logic [axil_pkg::ADDR_W-1:0]   s_awaddr_i,
	input  wire logic                          s_awvalid_i,
	output logic                               s_awready_o,

	input  wire logic [axil_pkg::DATA_W-1:0]   s_wdata_i,
	input  wire logic                          s_wvalid_i,
	output logic                               s_wready_o,

	output logic      [axil_pkg::RESP_W-1:0]   s_bresp_o,
	output logic                               s_bvalid_o,
	input  wire logic                          s_bready_i,

	input  wire logic [axil_pkg::ADDR_W-1:0]   s_araddr_i,
	input  wire logic                          s_arvalid_i,
	output logic                               s_arready_o,

	output logic      [axil_pkg::DATA_W-1:0]   s_rdata_o,
	output logic      [axil_pkg::RESP_W-1:0]   s_rresp_o,
	output logic                               s_rvalid_o,
	input  wire logic                          s_rready_i
);

	div_if div_bus ();  // register block to divider.

	axil_div_regs i_axil_div_regs (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.s_awaddr_i  (s_awaddr_i),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_wdata_i   (s_wdata_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_bresp_o   (s_bresp_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_araddr_i  (s_araddr_i),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.div_p       (div_bus.ctrl)
	);

	int_divider i_int_divider (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.div_p    (div_bus.core)
	);

endmodule

`default_nettype wire

// File: div_if.sv
`timescale 1ns/1ns
`default_nettype none

interface div_if;

	// command side.
	logic                     start;     // one-cycle pulse.
	mdu_pkg::div_op_e         op;
	logic [mdu_pkg::XLEN-1:0] dividend;
	logic [mdu_pkg::XLEN-1:0] divisor;

	// response side.
	logic                     busy;
	logic                     done;      // one-cycle pulse.
	logic [mdu_pkg::XLEN-1:0] result;    // held until next done.

	modport ctrl (
		output start,
		output op,
		output dividend,
		output divisor,
		input  busy,
		input  done,
		input  result
	);

	modport core (
		input  start,
		input  op,
		input  dividend,
		input  divisor,
		output busy,
		output done,
		output result
	);

endinterface

`default_nettype wire

// File: int_divider.sv
`timescale 1ns/1ns
`default_nettype none

module int_divider (
	input  wire logic clk_i,
	input  wire logic arst_n_i,
	div_if.core       div_p
);

	logic [mdu_pkg::DIV_ST_W-1:0] state_q;
	logic [mdu_pkg::CNT_W-1:0]    cnt_q;
	mdu_pkg::div_op_e             op_q;
	logic                         sign_a_q;    // dividend negative.
	logic                         sign_b_q;    // divisor negative.
	logic                         div_zero_q;
	logic                         ovf_q;

	logic [mdu_pkg::XLEN-1:0] dividend_q;
	logic [mdu_pkg::XLEN-1:0] divisor_q;
	logic [mdu_pkg::XLEN-1:0] dvsr_q;      // divisor magnitude.
	logic [mdu_pkg::XLEN-1:0] quo_q;       // dividend shifting out, quotient in.
	logic [mdu_pkg::XLEN-1:0] rem_q;
	logic [mdu_pkg::XLEN-1:0] result_q;

	logic                     start_ok;
	logic                     in_fixup;
	logic [mdu_pkg::XLEN:0]   trial;
	logic [mdu_pkg::XLEN-1:0] quo_fix;
	logic [mdu_pkg::XLEN-1:0] rem_fix;
	logic [mdu_pkg::XLEN-1:0] fix_res;

	assign start_ok = div_p.start && (state_q == mdu_pkg::ST_IDLE);
	assign in_fixup = (state_q == mdu_pkg::ST_FIXUP);

	// next dividend bit in, divisor out.
	assign trial = {rem_q, quo_q[mdu_pkg::XLEN-1]} - {1'b0, dvsr_q};

	// ========================================
	// sequencer
	// ========================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= mdu_pkg::ST_IDLE;
			cnt_q      <= '0;
			op_q       <= mdu_pkg::OP_DIVU;
			sign_a_q   <= 1'b0;
			sign_b_q   <= 1'b0;
			div_zero_q <= 1'b0;
			ovf_q      <= 1'b0;
		end else begin
			case (state_q)
				mdu_pkg::ST_IDLE: begin
					if (start_ok) begin
						state_q  <= mdu_pkg::ST_LOAD;
						op_q     <= div_p.op;
						sign_a_q <= div_p.op[1] & div_p.dividend[mdu_pkg::XLEN-1];
						sign_b_q <= div_p.op[1] & div_p.divisor[mdu_pkg::XLEN-1];
						// corner cases flagged up front.
						div_zero_q <= (div_p.divisor == '0);
						ovf_q      <= div_p.op[1] &&
							(div_p.dividend == {1'b1, {(mdu_pkg::XLEN-1){1'b0}}}) &&
							(div_p.divisor == '1);
					end
				end
				mdu_pkg::ST_LOAD: begin
					state_q <= mdu_pkg::ST_ITER;
					cnt_q   <= '0;
				end
				mdu_pkg::ST_ITER: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == '1) begin
						state_q <= mdu_pkg::ST_FIXUP;  // last step.
					end
				end
				default: begin
					state_q <= mdu_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// ========================================
	// datapath
	// ========================================
	always_ff @(posedge clk_i) begin
		case (state_q)
			mdu_pkg::ST_IDLE: begin
				if (start_ok) begin
					dividend_q <= div_p.dividend;
					divisor_q  <= div_p.divisor;
				end
			end
			mdu_pkg::ST_LOAD: begin
				dvsr_q <= sign_b_q ? ~divisor_q + 1'b1 : divisor_q;
				quo_q  <= sign_a_q ? ~dividend_q + 1'b1 : dividend_q;
				rem_q  <= '0;
			end
			mdu_pkg::ST_ITER: begin
				if (trial[mdu_pkg::XLEN]) begin
					// negative, keep the shifted remainder.
					rem_q <= {rem_q[mdu_pkg::XLEN-2:0], quo_q[mdu_pkg::XLEN-1]};
				end else begin
					rem_q <= trial[mdu_pkg::XLEN-1:0];
				end
				quo_q <= {quo_q[mdu_pkg::XLEN-2:0], ~trial[mdu_pkg::XLEN]};
			end
			default: begin
				result_q <= fix_res;
			end
		endcase
	end

	// sign fix-up and RISC-V special results.
	always_comb begin
		quo_fix = (sign_a_q ^ sign_b_q) ? ~quo_q + 1'b1 : quo_q;
		rem_fix = sign_a_q ? ~rem_q + 1'b1 : rem_q;  // follows the dividend.
		if (div_zero_q) begin
			quo_fix = '1;
			rem_fix = dividend_q;
		end else if (ovf_q) begin
			quo_fix = dividend_q;
			rem_fix = '0;
		end
		fix_res = op_q[0] ? rem_fix : quo_fix;
	end

	assign div_p.busy   = (state_q != mdu_pkg::ST_IDLE);
	assign div_p.done   = in_fixup;
	assign div_p.result = in_fixup ? fix_res : result_q;  // valid in the done cycle.

endmodule

`default_nettype wire

// File: mdu_pkg.sv
`default_nettype none

package mdu_pkg;

	// ========================================
	// datapath sizes
	// ========================================
	localparam int XLEN        = 32;
	localparam int CNT_W       = $clog2(XLEN);  // one count per step.
	localparam int DIV_LATENCY = 34;            // start cycle to done.

	// bit 1 signed, bit 0 remainder.
	typedef enum logic [1:0] {
		OP_DIVU = 2'b00,
		OP_REMU = 2'b01,
		OP_DIV  = 2'b10,
		OP_REM  = 2'b11
	} div_op_e;

	// divider sequencer states.
	localparam int                DIV_ST_W = 2;
	localparam logic [DIV_ST_W-1:0] ST_IDLE  = 2'd0;
	localparam logic [DIV_ST_W-1:0] ST_LOAD  = 2'd1;
	localparam logic [DIV_ST_W-1:0] ST_ITER  = 2'd2;
	localparam logic [DIV_ST_W-1:0] ST_FIXUP = 2'd3;

endpackage

`default_nettype wire

// File: tb_div_accel.sv
`timescale 1ns/1ns
`default_nettype none

module tb_div_accel;

	localparam int CLK_PERIOD  = 40;
	localparam int DRIVE_DLY   = 5;
	localparam int RST_CYCLES  = 10;
	localparam int SEED        = 25502;
	localparam int N_DIVS      = 51;  // every division started below.
	localparam int CYC_PER_DIV = 60;
	localparam int TIMEOUT_CYC = N_DIVS * CYC_PER_DIV + 1000;

	logic                        clk_i;
	logic                        arst_n_i;
	logic [axil_pkg::ADDR_W-1:0] s_awaddr_i;
	logic                        s_awvalid_i;
	logic                        s_awready_o;
	logic [axil_pkg::DATA_W-1:0] s_wdata_i;
	logic                        s_wvalid_i;
	logic                        s_wready_o;
	logic [axil_pkg::RESP_W-1:0] s_bresp_o;
	logic                        s_bvalid_o;
	logic                        s_bready_i;
	logic [axil_pkg::ADDR_W-1:0] s_araddr_i;
	logic                        s_arvalid_i;
	logic                        s_arready_o;
	logic [axil_pkg::DATA_W-1:0] s_rdata_o;
	logic [axil_pkg::RESP_W-1:0] s_rresp_o;
	logic                        s_rvalid_o;
	logic                        s_rready_i;

	int n_pass    = 0;
	int n_fail    = 0;
	int cycle_cnt = 0;

	div_accel_top i_div_accel_top (.*);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			$display("timeout: the run did not finish within %0d cycles.", TIMEOUT_CYC);
			$display("tests failed");
			$finish;
		end
	end

	// ========================================
	// checks and bus tasks
	// ========================================
	task automatic next_cycle();
		@(posedge clk_i);
		#DRIVE_DLY;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) begin
			n_pass++;
		end else begin
			$display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, exp, act);
			n_fail++;
		end
	endtask

	task automatic check_valid(input string name, input logic vld);
		assert (vld === 1'b1) begin
			n_pass++;
		end else begin
			$display("%s: response valid was low while waiting for ready.", name);
			n_fail++;
		end
	endtask

	function automatic int pick_delay(input bit bp_en);
		return bp_en ? $urandom_range(5, 0) : 0;
	endfunction

	task automatic axil_write(input string name, input logic [axil_pkg::ADDR_W-1:0] addr,
			input logic [31:0] data, input int bp_dly, output logic [1:0] resp);
		s_awaddr_i  = addr;
		s_wdata_i   = data;
		s_awvalid_i = 1'b1;
		s_wvalid_i  = 1'b1;
		s_bready_i  = (bp_dly == 0);
		@(negedge clk_i);
		while (!s_awready_o) begin
			@(negedge clk_i);
		end
		check_value({name, " wready"}, 1'b1, s_wready_o);
		next_cycle();  // handshake edge.
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		check_valid(name, s_bvalid_o);
		repeat (bp_dly) begin
			next_cycle();
			check_valid(name, s_bvalid_o);
		end
		s_bready_i = 1'b1;
		resp = s_bresp_o;
		next_cycle();
	endtask

	task automatic axil_read(input string name, input logic [axil_pkg::ADDR_W-1:0] addr,
			input int bp_dly, output logic [31:0] data, output logic [1:0] resp);
		s_araddr_i  = addr;
		s_arvalid_i = 1'b1;
		s_rready_i  = (bp_dly == 0);
		@(negedge clk_i);
		while (!s_arready_o) begin
			@(negedge clk_i);
		end
		next_cycle();
		s_arvalid_i = 1'b0;
		check_valid(name, s_rvalid_o);
		repeat (bp_dly) begin
			next_cycle();
			check_valid(name, s_rvalid_o);
		end
		s_rready_i = 1'b1;
		data = s_rdata_o;
		resp = s_rresp_o;
		next_cycle();
	endtask

	// RISC-V M-extension division rules.
	function automatic logic [31:0] expected_result(input mdu_pkg::div_op_e op,
			input logic [31:0] a, input logic [31:0] b);
		longint      sa;
		longint      sb;
		logic [31:0] q;
		logic [31:0] r;
		sa = op[1] ? longint'($signed(a)) : longint'(a);
		sb = op[1] ? longint'($signed(b)) : longint'(b);
		if (b == '0) begin
			q = '1;
			r = a;
		end else if (op[1] && a == 32'h8000_0000 && b == '1) begin
			q = a;
			r = '0;
		end else begin
			q = 32'(sa / sb);  // truncates toward zero.
			r = 32'(sa % sb);  // sign of the dividend.
		end
		return op[0] ? r : q;
	endfunction

	task automatic wait_done(input string name);
		logic [31:0] status;
		logic [1:0]  resp;
		status = '0;
		while (!status[1]) begin
			axil_read(name, axil_pkg::REG_STATUS, 0, status, resp);
		end
	endtask

	task automatic run_div(input string name, input mdu_pkg::div_op_e op,
			input logic [31:0] a, input logic [31:0] b, input bit bp_en);
		logic [1:0]  resp;
		logic [31:0] data;
		axil_write(name, axil_pkg::REG_OPA, a, pick_delay(bp_en), resp);
		check_value({name, " opa bresp"}, axil_pkg::RESP_OKAY, resp);
		axil_write(name, axil_pkg::REG_OPB, b, pick_delay(bp_en), resp);
		check_value({name, " opb bresp"}, axil_pkg::RESP_OKAY, resp);
		axil_write(name, axil_pkg::REG_CTRL, 32'(op), pick_delay(bp_en), resp);
		check_value({name, " ctrl bresp"}, axil_pkg::RESP_OKAY, resp);
		wait_done(name);
		axil_read(name, axil_pkg::REG_RESULT, pick_delay(bp_en), data, resp);
		check_value({name, " rresp"}, axil_pkg::RESP_OKAY, resp);
		check_value(name, expected_result(op, a, b), data);
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("test %-12s finished, %0d errors", name, n_fail - fails_before);
	endtask

	// ========================================
	// tests
	// ========================================
	task automatic unsigned_ops();
		logic [31:0] a;
		logic [31:0] b;
		int          errs;
		errs = n_fail;
		for (int i = 0; i < 10; i++) begin
			a = $urandom();
			b = $urandom() >> $urandom_range(31, 0);  // spread of quotient sizes.
			run_div("divu", mdu_pkg::OP_DIVU, a, b, 1'b0);
			run_div("remu", mdu_pkg::OP_REMU, a, b, 1'b0);
		end
		report_test("unsigned", errs);
	endtask

	task automatic signed_ops();
		logic [31:0] a;
		logic [31:0] b;
		int          errs;
		errs = n_fail;
		for (int i = 0; i < 10; i++) begin
			a = $urandom() & 32'h7fff_ffff;
			b = ($urandom() >> $urandom_range(30, 1)) | 32'h1;
			if (i % 2 == 1) begin
				a = ~a + 1'b1;
			end
			if ((i / 2) % 2 == 1) begin
				b = ~b + 1'b1;
			end
			run_div("div", mdu_pkg::OP_DIV, a, b, 1'b0);
			run_div("rem", mdu_pkg::OP_REM, a, b, 1'b0);
		end
		report_test("signed", errs);
	endtask

	task automatic zero_divisor();
		logic [31:0] a;
		int          errs;
		errs = n_fail;
		a = $urandom() | 32'h8000_0000;  // negative when signed.
		run_div("zero_divu", mdu_pkg::OP_DIVU, a, '0, 1'b0);
		run_div("zero_remu", mdu_pkg::OP_REMU, a, '0, 1'b0);
		run_div("zero_div", mdu_pkg::OP_DIV, a, '0, 1'b0);
		run_div("zero_rem", mdu_pkg::OP_REM, a, '0, 1'b0);
		report_test("div_by_zero", errs);
	endtask

	task automatic signed_overflow();
		int errs;
		errs = n_fail;
		run_div("ovf_div", mdu_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		run_div("ovf_rem", mdu_pkg::OP_REM, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		report_test("overflow", errs);
	endtask

	task automatic access_errors();
		logic [1:0]  resp;
		logic [31:0] data;
		logic [31:0] a;
		logic [31:0] b;
		int          errs;
		errs = n_fail;
		a = $urandom();
		b = ($urandom() >> 12) | 32'h1;
		axil_write("busy", axil_pkg::REG_OPA, a, 0, resp);
		axil_write("busy", axil_pkg::REG_OPB, b, 0, resp);
		axil_write("busy", axil_pkg::REG_CTRL, 32'(mdu_pkg::OP_REMU), 0, resp);
		check_value("busy first ctrl", axil_pkg::RESP_OKAY, resp);
		axil_write("busy", axil_pkg::REG_CTRL, 32'(mdu_pkg::OP_DIV), 0, resp);
		check_value("busy second ctrl", axil_pkg::RESP_SLVERR, resp);
		wait_done("busy");
		axil_read("busy", axil_pkg::REG_RESULT, 0, data, resp);
		check_value("busy result", expected_result(mdu_pkg::OP_REMU, a, b), data);
		axil_read("busy", axil_pkg::REG_CTRL, 0, data, resp);
		check_value("busy ctrl kept", 32'(mdu_pkg::OP_REMU), data);
		axil_read("unmapped", 8'h14, 0, data, resp);
		check_value("unmapped rresp", axil_pkg::RESP_DECERR, resp);
		axil_write("read_only", axil_pkg::REG_STATUS, '1, 0, resp);
		check_value("read_only bresp", axil_pkg::RESP_DECERR, resp);
		report_test("access", errs);
	endtask

	task automatic back_pressure();
		logic [31:0] a;
		logic [31:0] b;
		int          errs;
		errs = n_fail;
		for (int i = 0; i < 4; i++) begin
			a = $urandom();
			b = $urandom() >> $urandom_range(24, 0);
			run_div("backpressure", mdu_pkg::div_op_e'(i[1:0]), a, b, 1'b1);
		end
		report_test("backpressure", errs);
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		int sva_fails;
		void'($urandom(SEED));
		arst_n_i    = 1'b0;
		s_awaddr_i  = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i   = '0;
		s_wvalid_i  = 1'b0;
		s_bready_i  = 1'b1;
		s_araddr_i  = '0;
		s_arvalid_i = 1'b0;
		s_rready_i  = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_i);
		#DRIVE_DLY;
		arst_n_i = 1'b1;
		next_cycle();
		unsigned_ops();
		signed_ops();
		zero_divisor();
		signed_overflow();
		access_errors();
		back_pressure();
		sva_fails = i_div_accel_top.i_div_accel_sva.fail_cnt;
		$display("summary: %0d checks passed, %0d checks failed, %0d assertion failures",
			n_pass, n_fail, sva_fails);
		if (n_fail == 0 && sva_fails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_div_accel_sva.sv
`timescale 1ns/1ns
`default_nettype none

module div_accel_sva (
	input wire logic                        clk_i,
	input wire logic                        arst_n_i,
	input wire logic                        bvalid_i,
	input wire logic                        bready_i,
	input wire logic [axil_pkg::RESP_W-1:0] bresp_i,
	input wire logic                        rvalid_i,
	input wire logic                        rready_i,
	input wire logic                        start_i,
	input wire logic                        busy_i,
	input wire logic                        done_i
);

	int fail_cnt = 0;  // failed assertions so far.

	// ========================================
	// bus responses
	// ========================================
	b_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		bvalid_i && !bready_i |=> bvalid_i)
		else begin
			$error("bvalid dropped before bready.");
			fail_cnt++;
		end

	b_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		bvalid_i && !bready_i |=> $stable(bresp_i))
		else begin
			$error("bresp changed while bvalid was held.");
			fail_cnt++;
		end

	r_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		rvalid_i && !rready_i |=> rvalid_i)
		else begin
			$error("rvalid dropped before rready.");
			fail_cnt++;
		end

	// ========================================
	// divider timing
	// ========================================
	done_on_time: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		start_i && !busy_i |-> ##(mdu_pkg::DIV_LATENCY) done_i)
		else begin
			$error("done did not follow start after the fixed latency.");
			fail_cnt++;
		end

	done_not_early: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		start_i && !busy_i |=> !done_i [*(mdu_pkg::DIV_LATENCY - 1)])
		else begin
			$error("done came before the fixed latency.");
			fail_cnt++;
		end

	busy_until_done: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$fell(busy_i) |-> $past(done_i))
		else begin
			$error("busy fell without a done pulse.");
			fail_cnt++;
		end

endmodule

bind div_accel_top div_accel_sva i_div_accel_sva (
	.clk_i    (clk_i),
	.arst_n_i (arst_n_i),
	.bvalid_i (s_bvalid_o),
	.bready_i (s_bready_i),
	.bresp_i  (s_bresp_o),
	.rvalid_i (s_rvalid_o),
	.rready_i (s_rready_i),
	.start_i  (div_bus.start),
	.busy_i   (div_bus.busy),
	.done_i   (div_bus.done)
);

`default_nettype wire
